//--- bus_slave_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_slave_ctrl (
  input  logic                  BUS,
  input  logic                  rst,
  // Bus request side
  input  gpio_pkg::bus_addr_t   addr,
  input  gpio_pkg::bus_data_t   write_data,
  input  logic                  rnw,
  input  logic                  valid,
  // Bus response side
  output logic                  ready,
  output logic                  error,
  output gpio_pkg::bus_data_t   read_data,
  // Toward the output bank and the input synchronizer
  output gpio_pkg::word_index_t word_index,
  output logic                  gpo_wr_en,
  output gpio_pkg::bus_data_t   gpo_wr_data,
  input  gpio_pkg::bus_data_t   gpo_rd_word,
  input  gpio_pkg::bus_data_t   gpi_rd_word
);

  import gpio_pkg::*;

  // FSM state
  ctrl_state_t state;

  // Remaining wait states, loaded on the first valid edge
  logic [1:0]  wait_cnt;

  // Address decode results
  logic        aligned;
  logic        gpo_hit;
  logic        gpi_hit;
  logic        legal;

  // High in the cycle that ends with the response edge
  logic        last_wait;

  // Word picked for a read, output bank or input pins
  bus_data_t   rd_word;

  // ------------------------------
  // Address decode
  // ------------------------------

  // Only whole-word accesses are accepted
  assign aligned = (addr[1:0] == 2'b00);

  // Both windows are 32 bytes and 32-byte aligned,
  // so the upper bits alone pick the window
  assign gpo_hit = aligned && (addr[31:5] == GPO_BASE[31:5]);
  assign gpi_hit = aligned && (addr[31:5] == GPI_BASE[31:5]);

  // Input window is read only
  assign legal = gpo_hit || (gpi_hit && rnw);

  // Word within the selected window
  assign word_index = addr[4:2];

  // Read source by window
  assign rd_word = gpi_hit ? gpi_rd_word : gpo_rd_word;

  // ------------------------------
  // Write strobe
  // ------------------------------

  // Last wait cycle of a transaction still held by the master
  assign last_wait = (state == WAIT) && valid && (wait_cnt == 2'd0);

  // Strobe lands on the same edge that raises ready,
  // so gp_op already shows the new word in the ready cycle
  assign gpo_wr_en = last_wait && legal && !rnw;

  // Write data is held stable by the master until ready
  assign gpo_wr_data = write_data;

  // ------------------------------
  // FSM and response
  // ------------------------------

  always_ff @(posedge BUS) begin
    if (rst) begin
      state     <= IDLE;
      wait_cnt  <= 2'd0;
      ready     <= 1'b0;
      error     <= 1'b0;
      read_data <= '0;
    end else begin
      case (state)

        IDLE: begin
          ready <= 1'b0;
          error <= 1'b0;
          // Start counting on the first edge that sees valid
          if (valid) begin
            state <= WAIT;
            // Count includes the response edge itself
            if (rnw) begin
              wait_cnt <= 2'(RD_WAIT - 1);
            end else begin
              wait_cnt <= 2'(WR_WAIT - 1);
            end
          end
        end

        WAIT: begin
          if (!valid) begin
            // Master gave up, drop the access without a strobe
            state <= IDLE;
          end else if (wait_cnt == 2'd0) begin
            state <= RESP;
            ready <= 1'b1;
            error <= !legal;
            // Load read data only for a legal read
            // otherwise it keeps the last read value
            if (legal && rnw) begin
              read_data <= rd_word;
            end
          end else begin
            wait_cnt <= wait_cnt - 2'd1;
          end
        end

        RESP: begin
          // Ready is a single-cycle pulse
          state <= IDLE;
          ready <= 1'b0;
          error <= 1'b0;
        end

        default: begin
          state <= IDLE;
          ready <= 1'b0;
          error <= 1'b0;
        end

      endcase
    end
  end

endmodule

`default_nettype wire

//--- gpi_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gpi_sync (
  input  logic                  BUS,
  input  logic                  rst,
  // Asynchronous input pins
  input  gpio_pkg::gpio_vec_t   gp_ip,
  // Word select from the front end
  input  gpio_pkg::word_index_t word_index,
  // Synchronized word toward the bus
  output gpio_pkg::bus_data_t   gpi_rd_word
);

  import gpio_pkg::*;

  // ------------------------------
  // Two-stage synchronizer
  // ------------------------------

  // First stage may go metastable
  gpio_vec_t sync_meta;

  // Second stage is safe to use in the BUS domain
  gpio_vec_t sync_q;

  always_ff @(posedge BUS) begin
    if (rst) begin
      sync_meta <= '0;
      sync_q    <= '0;
    end else begin
      sync_meta <= gp_ip;
      sync_q    <= sync_meta;
    end
  end

  // ------------------------------
  // Word select
  // ------------------------------

  // Pin change shows here two edges later
  assign gpi_rd_word = sync_q[word_index*$bits(bus_data_t) +: $bits(bus_data_t)];

endmodule

`default_nettype wire

//--- gpio_pkg.sv
`default_nettype none

package gpio_pkg;

  // ------------------------------
  // Bus and pin widths
  // ------------------------------

  // Byte address as seen on the bus
  typedef logic [31:0]  bus_addr_t;

  // One bus data word
  typedef logic [31:0]  bus_data_t;

  // Full pin vector, same width for outputs and inputs
  typedef logic [255:0] gpio_vec_t;

  // Word select within a pin vector, taken from addr[4:2]
  typedef logic [2:0]   word_index_t;

  // ------------------------------
  // Address map
  // ------------------------------

  // Output register bank, eight words, read and write
  localparam bus_addr_t GPO_BASE = 32'h0100_0000;

  // Synchronized input words, eight words, read only
  localparam bus_addr_t GPI_BASE = 32'h0100_0020;

  // Words per pin vector
  localparam int NUM_WORDS = 8;

  // ------------------------------
  // Bus timing
  // ------------------------------

  // Wait states ahead of the response
  localparam int WR_WAIT = 2;
  localparam int RD_WAIT = 3;

  // Front end FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top (
  input  logic                BUS,
  input  logic                rst,
  // Bus slave port
  input  gpio_pkg::bus_addr_t addr,
  input  gpio_pkg::bus_data_t write_data,
  input  logic                rnw,
  input  logic                valid,
  output logic                ready,
  output logic                error,
  output gpio_pkg::bus_data_t read_data,
  // Pins
  output gpio_pkg::gpio_vec_t gp_op,
  input  gpio_pkg::gpio_vec_t gp_ip
);

  import gpio_pkg::*;

  // ------------------------------
  // Internal nets
  // ------------------------------

  // Word select shared by both banks
  word_index_t word_index;

  // Output bank write port
  logic        gpo_wr_en;
  bus_data_t   gpo_wr_data;

  // Read words back to the front end
  bus_data_t   gpo_rd_word;
  bus_data_t   gpi_rd_word;

  // ------------------------------
  // Bus front end
  // ------------------------------

  bus_slave_ctrl u_ctrl (
    .BUS         (BUS),
    .rst         (rst),
    .addr        (addr),
    .write_data  (write_data),
    .rnw         (rnw),
    .valid       (valid),
    .ready       (ready),
    .error       (error),
    .read_data   (read_data),
    .word_index  (word_index),
    .gpo_wr_en   (gpo_wr_en),
    .gpo_wr_data (gpo_wr_data),
    .gpo_rd_word (gpo_rd_word),
    .gpi_rd_word (gpi_rd_word)
  );

  // ------------------------------
  // Output bank
  // ------------------------------

  gpo_regs u_gpo (
    .BUS         (BUS),
    .rst         (rst),
    .gpo_wr_en   (gpo_wr_en),
    .word_index  (word_index),
    .gpo_wr_data (gpo_wr_data),
    .gpo_rd_word (gpo_rd_word),
    .gp_op       (gp_op)
  );

  // Input synchronizer
  gpi_sync u_gpi (
    .BUS         (BUS),
    .rst         (rst),
    .gp_ip       (gp_ip),
    .word_index  (word_index),
    .gpi_rd_word (gpi_rd_word)
  );

endmodule

`default_nettype wire

//--- gpo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpo_regs (
  input  logic                  BUS,
  input  logic                  rst,
  // Write port from the bus front end
  input  logic                  gpo_wr_en,
  input  gpio_pkg::word_index_t word_index,
  input  gpio_pkg::bus_data_t   gpo_wr_data,
  // Read-back word for the front end
  output gpio_pkg::bus_data_t   gpo_rd_word,
  // Output pins
  output gpio_pkg::gpio_vec_t   gp_op
);

  import gpio_pkg::*;

  // ------------------------------
  // Storage
  // ------------------------------

  // Eight output words with word 0 on gp_op[31:0]
  bus_data_t out_word [NUM_WORDS];

  // One whole word per write strobe
  always_ff @(posedge BUS) begin
    if (rst) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        out_word[i] <= '0;
      end
    end else if (gpo_wr_en) begin
      // No byte enables here
      out_word[word_index] <= gpo_wr_data;
    end
  end

  // ------------------------------
  // Pin vector
  // ------------------------------

  // Concatenate the bank with the lowest word at the bottom
  always_comb begin
    gp_op = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      gp_op[i*$bits(bus_data_t) +: $bits(bus_data_t)] = out_word[i];
    end
  end

  // ------------------------------
  // Read-back
  // ------------------------------

  // Indexed word with no clock edge in between
  // the front end registers it on the response edge
  assign gpo_rd_word = out_word[word_index];

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                BUS,
  input  logic                rst,
  // Bus as seen by the master
  input  gpio_pkg::bus_addr_t addr,
  input  gpio_pkg::bus_data_t write_data,
  input  logic                rnw,
  input  logic                valid,
  input  logic                ready,
  input  logic                error,
  input  gpio_pkg::bus_data_t read_data,
  // Pins
  input  gpio_pkg::gpio_vec_t gp_op,
  input  gpio_pkg::gpio_vec_t gp_ip,
  // Test sequencing from the testbench top
  input  logic [2:0]          test_num,
  input  logic                run_done,
  output int                  fail_count
);

  import gpio_pkg::*;

  // Reference model of the output bank and of the last read value
  bus_data_t model_word [NUM_WORDS];
  bus_data_t last_rd;

  // Transaction captured on its first edge
  logic      busy;
  bus_addr_t tx_addr;
  logic      tx_rnw;
  bus_data_t tx_wdata;
  gpio_vec_t tx_ip;
  int        tx_test;
  int        edge_cnt;
  int        exp_edges;
  logic      legal;

  // Bookkeeping
  logic      prev_rst;
  logic      done_seen;
  int        last_test;
  int        checks [1:5];
  int        fails  [1:5];

  // ------------------------------
  // Map rules
  // ------------------------------

  // Aligned and in the output window, or in the input window for a read
  function automatic logic access_legal(bus_addr_t a, logic r);
    logic in_gpo;
    logic in_gpi;
    in_gpo = (a >= GPO_BASE) && (a < GPO_BASE + 4 * NUM_WORDS);
    in_gpi = (a >= GPI_BASE) && (a < GPI_BASE + 4 * NUM_WORDS);
    return (a % 4 == 0) && (in_gpo || (in_gpi && r));
  endfunction

  // Word number inside whichever window a legal address hits
  function automatic int word_slot(bus_addr_t a);
    return (a >= GPI_BASE) ? (a - GPI_BASE) / 4 : (a - GPO_BASE) / 4;
  endfunction

  // Expected pin vector, word 0 at the bottom
  function automatic gpio_vec_t model_vec();
    gpio_vec_t v;
    for (int i = 0; i < NUM_WORDS; i++) begin
      v[i*32 +: 32] = model_word[i];
    end
    return v;
  endfunction

  function automatic string test_name(int t);
    case (t)
      1:       return "reset values";
      2:       return "output write and read-back";
      3:       return "input read";
      4:       return "illegal accesses";
      default: return "response timing";
    endcase
  endfunction

  // ------------------------------
  // Reporting
  // ------------------------------

  task automatic check_value(input int t, input string name,
                             input logic [255:0] exp, input logic [255:0] got);
    checks[t]++;
    if (exp !== got) begin
      fails[t]++;
      fail_count++;
      $display("Fail %s expected %0h got %0h", name, exp, got);
    end
  endtask

  // Timing faults go to the timing test
  task automatic report_problem(input string msg);
    checks[5]++;
    fails[5]++;
    fail_count++;
    $display("Error: %s", msg);
  endtask

  task automatic print_test(input int t);
    $display("test %0d %s: %0d checks, %0d failed",
             t, test_name(t), checks[t], fails[t]);
  endtask

  // ------------------------------
  // Watcher
  // ------------------------------

  // Sampled on the rising edge, so all values are those of the cycle just ended
  always @(posedge BUS) begin
    if (rst) begin
      busy       = 1'b0;
      prev_rst   = 1'b1;
      done_seen  = 1'b0;
      last_test  = test_num;
      last_rd    = '0;
      fail_count = 0;
      for (int i = 0; i < NUM_WORDS; i++) begin
        model_word[i] = '0;
      end
      for (int t = 1; t <= 5; t++) begin
        checks[t] = 0;
        fails[t]  = 0;
      end
    end else begin
      // Pins come out of reset low
      if (prev_rst) begin
        check_value(1, "gp_op", '0, gp_op);
      end
      prev_rst = 1'b0;

      if (busy) begin
        edge_cnt++;
        if (ready) begin
          busy  = 1'b0;
          legal = access_legal(tx_addr, tx_rnw);
          check_value(5, "ready latency", exp_edges, edge_cnt);
          check_value(tx_test, "error", !legal, error);
          if (legal && !tx_rnw) begin
            model_word[word_slot(tx_addr)] = tx_wdata;
          end
          // Pins follow the model after every access, legal or not
          check_value(tx_test, "gp_op", model_vec(), gp_op);
          if (tx_rnw) begin
            if (legal && tx_addr >= GPI_BASE) begin
              last_rd = tx_ip[word_slot(tx_addr)*32 +: 32];
            end else if (legal) begin
              last_rd = model_word[word_slot(tx_addr)];
            end
            check_value(tx_test, "read_data", last_rd, read_data);
          end
        end else if (edge_cnt > exp_edges) begin
          busy = 1'b0;
          report_problem("no ready within the wait count of an access");
        end
      end else begin
        if (ready) begin
          report_problem("ready is high with no access in progress");
        end
        // First edge that sees valid starts the count
        if (valid) begin
          busy      = 1'b1;
          edge_cnt  = 0;
          tx_addr   = addr;
          tx_rnw    = rnw;
          tx_wdata  = write_data;
          tx_ip     = gp_ip;
          tx_test   = test_num;
          exp_edges = (rnw ? RD_WAIT : WR_WAIT) + 1;
        end
      end

      // One line per test as the sequence moves on
      if (test_num != last_test) begin
        print_test(last_test);
        last_test = test_num;
      end
      if (run_done && !done_seen) begin
        done_seen = 1'b1;
        print_test(last_test);
        print_test(5);
        $display("checks passed %0d, failed %0d",
                 checks[1] + checks[2] + checks[3] + checks[4] + checks[5] - fail_count,
                 fail_count);
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import gpio_pkg::*;

  // Transactions per test
  localparam int N_WR    = 32;
  localparam int N_IP    = 24;
  localparam int N_BAD   = 32;
  localparam int N_TXN   = NUM_WORDS + N_WR + N_WR / 2 + N_IP + N_BAD;
  // At most 8 cycles per access, plus reset and slack
  localparam int LIMIT   = N_TXN * 8 + 5 + 100;

  logic        BUS;
  logic        rst;
  bus_addr_t   addr;
  bus_data_t   write_data;
  logic        rnw;
  logic        valid;
  logic        ready;
  logic        error;
  bus_data_t   read_data;
  gpio_vec_t   gp_op;
  gpio_vec_t   gp_ip;
  logic [2:0]  test_num;
  logic        run_done;
  int          fail_count;
  int          cycle_cnt;

  gpio_top dut0 (
    .BUS        (BUS),
    .rst        (rst),
    .addr       (addr),
    .write_data (write_data),
    .rnw        (rnw),
    .valid      (valid),
    .ready      (ready),
    .error      (error),
    .read_data  (read_data),
    .gp_op      (gp_op),
    .gp_ip      (gp_ip)
  );

  tb_checker chk0 (
    .BUS        (BUS),
    .rst        (rst),
    .addr       (addr),
    .write_data (write_data),
    .rnw        (rnw),
    .valid      (valid),
    .ready      (ready),
    .error      (error),
    .read_data  (read_data),
    .gp_op      (gp_op),
    .gp_ip      (gp_ip),
    .test_num   (test_num),
    .run_done   (run_done),
    .fail_count (fail_count)
  );

  // ------------------------------
  // Clock and timeout
  // ------------------------------

  initial begin
    BUS = 1'b0;
    forever #20 BUS = ~BUS;
  end

  initial begin
    cycle_cnt = 0;
  end

  always @(posedge BUS) begin
    cycle_cnt++;
    if (cycle_cnt > LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Bus master
  // ------------------------------

  // Entered on a falling edge, returns one idle cycle after ready
  task automatic bus_access(input bus_addr_t a, input logic r, input bus_data_t d);
    addr       = a;
    rnw        = r;
    write_data = d;
    valid      = 1'b1;
    do begin
      @(negedge BUS);
    end while (!ready);
    valid = 1'b0;
    @(negedge BUS);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    word_index_t idx;
    bus_addr_t   a;
    int          kind;
    void'($urandom(32'h55fb));
    rst        = 1'b1;
    addr       = '0;
    write_data = '0;
    rnw        = 1'b0;
    valid      = 1'b0;
    gp_ip      = '0;
    test_num   = 3'd1;
    run_done   = 1'b0;
    repeat (5) @(negedge BUS);
    rst = 1'b0;
    @(negedge BUS);

    // Every output word reads zero after reset
    for (int i = 0; i < NUM_WORDS; i++) begin
      bus_access(GPO_BASE + 4 * i, 1'b1, '0);
    end

    // Random writes with a read-back after every second one
    test_num = 3'd2;
    for (int i = 0; i < N_WR; i++) begin
      idx = $urandom_range(0, NUM_WORDS - 1);
      bus_access(GPO_BASE + 4 * idx, 1'b0, $urandom);
      if (i % 2 == 1) begin
        idx = $urandom_range(0, NUM_WORDS - 1);
        bus_access(GPO_BASE + 4 * idx, 1'b1, '0);
      end
    end

    // New pin values settle through the synchronizer before the read
    test_num = 3'd3;
    for (int i = 0; i < N_IP; i++) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        gp_ip[w*32 +: 32] = $urandom;
      end
      repeat (3) @(negedge BUS);
      idx = $urandom_range(0, NUM_WORDS - 1);
      bus_access(GPI_BASE + 4 * idx, 1'b1, '0);
    end

    // Outside the map, unaligned, or a write to the input window
    test_num = 3'd4;
    for (int i = 0; i < N_BAD; i++) begin
      kind = $urandom_range(0, 2);
      idx  = $urandom_range(0, NUM_WORDS - 1);
      if (kind == 0) begin
        do begin
          a = $urandom;
        end while (a >= GPO_BASE && a < GPI_BASE + 4 * NUM_WORDS);
        bus_access(a, $urandom_range(0, 1), $urandom);
      end else if (kind == 1) begin
        a = ($urandom_range(0, 1) ? GPO_BASE : GPI_BASE) + 4 * idx + $urandom_range(1, 3);
        bus_access(a, $urandom_range(0, 1), $urandom);
      end else begin
        bus_access(GPI_BASE + 4 * idx, 1'b0, $urandom);
      end
    end

    // Let the checker print its summary first
    run_done = 1'b1;
    repeat (2) @(negedge BUS);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
gpio_pkg.sv
gpi_sync.sv
gpo_regs.sv
bus_slave_ctrl.sv
gpio_top.sv
tb_checker.sv
tb_top.sv
